//--- design/qsic_pkg.sv
// qsic shared definitions
`default_nettype none

package qsic_pkg;

   // bus and register widths
   localparam int dal_width      = 22;  // BDAL<21:0>
   localparam int data_width     = 16;  // register word
   localparam int reg_addr_width = 13;  // low bits decoded inside the I/O page

   // panel configuration register, I/O page offset 17720 (octal)
   localparam logic [reg_addr_width-1:0] conf_addr = 13'o17720;

   // register field layout
   localparam int sel_width   = 2;   // one panel selection
   localparam int slot_stride = 3;   // slot i sits at bit i*3, with a zero bit between slots
   localparam int slot_count  = 4;
   localparam int count_lsb   = 12;  // count field at bits 13:12

   localparam int panel_bits = 36;   // lamps on one indicator panel

   // what a slot puts on the panel chain
   typedef enum logic [1:0] {
      panel_lamptest    = 2'd0,  // every lamp on
      panel_bus_monitor = 2'd1,  // last bus cycle address
      panel_config_echo = 2'd2,  // the config register itself
      panel_dark        = 2'd3   // every lamp off
   } panel_sel_t;

   // slave reply FSM
   typedef enum logic [2:0] {
      idle,
      read_settle,  // transceivers turned, waiting out the settle time
      read_drive,   // data latched and driven, reply asserted
      write_ack     // write taken, reply asserted
   } reply_state_t;

   typedef panel_sel_t panel_list_t [slot_count];

   // power-up panel layout: echo, monitor, lamptest, monitor
   localparam panel_list_t conf_list_reset = '{
      panel_config_echo,
      panel_bus_monitor,
      panel_lamptest,
      panel_bus_monitor
   };
   localparam logic [1:0] conf_count_reset = 2'd2;  // show slots 0..2

endpackage

`default_nettype wire

//--- design/qbus_sync.sv
// qbus strobe synchronizer
`timescale 1ns/1ps
`default_nettype none

module qbus_sync #(
   parameter int sync_stages   = 2,  // flops per synchronizer, 2 or more
   parameter int settle_cycles = 2   // extra delay on the read strobe for cable settling
) (
   input  wire logic                           clk20,
   input  wire logic                           reset,
   input  wire logic                           rsync,
   input  wire logic                           rdin,
   input  wire logic                           rdout,
   input  wire logic                           bs7,
   input  wire logic                           wtbt,
   input  wire logic [qsic_pkg::dal_width-1:0] dal_in,
   output logic                                s_rsync,
   output logic                                s_rdin,
   output logic                                rdin_settled,
   output logic                                s_rdout,
   output logic                                rdout_pulse,
   output logic                                cycle_bs7,
   output logic                                cycle_read,
   output logic [qsic_pkg::dal_width-1:0]      cycle_addr
);

   localparam int rdin_len = sync_stages + settle_cycles;

   logic [sync_stages-1:0] rsync_sr;  // newest sample in bit 0
   logic [sync_stages-1:0] rdout_sr;
   logic [rdin_len-1:0]    rdin_sr;   // sync stages, then the settle tail
   logic                   rsync_last;
   logic                   rdout_last;
   logic                   rsync_rise;

   always_ff @(posedge clk20) begin
      if (reset) begin
         rsync_sr   <= '0;
         rdout_sr   <= '0;
         rdin_sr    <= '0;
         rsync_last <= 1'b0;
         rdout_last <= 1'b0;
      end else begin
         rsync_sr   <= {rsync_sr[sync_stages-2:0], rsync};
         rdout_sr   <= {rdout_sr[sync_stages-2:0], rdout};
         rdin_sr    <= {rdin_sr[rdin_len-2:0], rdin};
         rsync_last <= s_rsync;
         rdout_last <= s_rdout;
      end
   end

   assign s_rsync      = rsync_sr[sync_stages-1];
   assign s_rdout      = rdout_sr[sync_stages-1];
   assign s_rdin       = rdin_sr[sync_stages-1];
   assign rdin_settled = rdin_sr[rdin_len-1];  // s_rdin, settle_cycles later

   assign rsync_rise  = s_rsync & ~rsync_last;
   assign rdout_pulse = s_rdout & ~rdout_last;  // one clock per DATO

   // address phase capture, master still holds the address lines here
   always_ff @(posedge clk20) begin
      if (reset) begin
         cycle_addr <= '0;
         cycle_bs7  <= 1'b0;
         cycle_read <= 1'b0;
      end else if (rsync_rise) begin
         cycle_addr <= dal_in;
         cycle_bs7  <= bs7;
         cycle_read <= ~wtbt;  // wtbt low in the address phase means DATI
      end
   end

endmodule

`default_nettype wire

//--- design/reply_seq.sv
// slave reply sequencer
`timescale 1ns/1ps
`default_nettype none

module reply_seq #(
   // read settle time in clocks
   // the delay itself arrives already applied on rdin_settled
   parameter int settle_cycles = 2
) (
   input  wire logic clk20,
   input  wire logic reset,
   input  wire logic conf_match,    // cycle addresses one of our registers
   input  wire logic s_rdin,
   input  wire logic rdin_settled,
   input  wire logic s_rdout,
   output logic      trply,
   output logic      dal_tx,        // transceivers toward the bus
   output logic      dal_st,        // latch outgoing data
   output logic      dal_be_l       // bus drivers enable, active low
);

   qsic_pkg::reply_state_t state;
   qsic_pkg::reply_state_t next;

   always_comb begin
      next = state;
      case (state)
         qsic_pkg::idle: begin
            if (conf_match && s_rdin)
               next = qsic_pkg::read_settle;  // DATI to us
            else if (conf_match && s_rdout)
               next = qsic_pkg::write_ack;    // DATO to us
         end
         qsic_pkg::read_settle: begin
            if (!s_rdin)
               next = qsic_pkg::idle;         // master gave up early
            else if (rdin_settled)
               next = qsic_pkg::read_drive;
         end
         qsic_pkg::read_drive: begin
            if (!s_rdin)
               next = qsic_pkg::idle;
         end
         qsic_pkg::write_ack: begin
            if (!s_rdout)
               next = qsic_pkg::idle;
         end
         default: next = qsic_pkg::idle;
      endcase
   end

   // outputs registered off the next state so they come out of flops, glitch free
   always_ff @(posedge clk20) begin
      if (reset) begin
         state    <= qsic_pkg::idle;
         trply    <= 1'b0;
         dal_tx   <= 1'b0;
         dal_st   <= 1'b0;
         dal_be_l <= 1'b1;
      end else begin
         state    <= next;
         trply    <= (next == qsic_pkg::read_drive) || (next == qsic_pkg::write_ack);
         dal_tx   <= (next == qsic_pkg::read_settle) || (next == qsic_pkg::read_drive);
         dal_st   <= (next == qsic_pkg::read_drive);
         dal_be_l <= (next != qsic_pkg::read_drive);  // drive bus only with data latched
      end
   end

endmodule

`default_nettype wire

//--- design/panel_config.sv
// panel configuration register
`timescale 1ns/1ps
`default_nettype none

module panel_config (
   input  wire logic                            clk20,
   input  wire logic                            reset,
   input  wire logic                            s_rsync,
   input  wire logic                            rdout_pulse,
   input  wire logic                            cycle_bs7,
   input  wire logic [qsic_pkg::dal_width-1:0]  cycle_addr,
   input  wire logic [qsic_pkg::dal_width-1:0]  dal_in,
   output logic                                 conf_match,
   output logic [qsic_pkg::data_width-1:0]      read_data,
   output qsic_pkg::panel_sel_t                 conf_list [qsic_pkg::slot_count],
   output logic [1:0]                           conf_count
);

   logic conf_write;

   // I/O page hit on 17720, only while the cycle is still open
   assign conf_match = s_rsync && cycle_bs7 &&
      (cycle_addr[qsic_pkg::reg_addr_width-1:0] == qsic_pkg::conf_addr);

   assign conf_write = rdout_pulse && conf_match;  // data phase of a DATO

   always_ff @(posedge clk20) begin
      if (reset) begin
         conf_list  <= qsic_pkg::conf_list_reset;
         conf_count <= qsic_pkg::conf_count_reset;
      end else if (conf_write) begin
         for (int i = 0; i < qsic_pkg::slot_count; i++) begin
            conf_list[i] <= qsic_pkg::panel_sel_t'(
               dal_in[i*qsic_pkg::slot_stride +: qsic_pkg::sel_width]);
         end
         conf_count <= dal_in[qsic_pkg::count_lsb +: 2];
      end
   end

   // read-back word, gap bits and upper bits read as zero
   always_comb begin
      read_data = '0;
      for (int i = 0; i < qsic_pkg::slot_count; i++) begin
         read_data[i*qsic_pkg::slot_stride +: qsic_pkg::sel_width] = conf_list[i];
      end
      read_data[qsic_pkg::count_lsb +: 2] = conf_count;
   end

endmodule

`default_nettype wire

//--- design/panel_scan.sv
// indicator panel scanner
`timescale 1ns/1ps
`default_nettype none

module panel_scan #(
   parameter int ip_div = 4  // clk20 cycles per half period of ip_clk, 2 or more
) (
   input  wire logic                            clk20,
   input  wire logic                            reset,
   input  wire logic                            cycle_read,
   input  wire logic                            cycle_bs7,
   input  wire logic [qsic_pkg::dal_width-1:0]  cycle_addr,
   input  wire logic [qsic_pkg::data_width-1:0] read_data,
   input  wire qsic_pkg::panel_sel_t            conf_list [qsic_pkg::slot_count],
   input  wire logic [1:0]                      conf_count,
   output logic                                 ip_clk,
   output logic                                 ip_out,
   output logic                                 ip_latch
);

   localparam int pb    = qsic_pkg::panel_bits;
   localparam int div_w = $clog2(ip_div);
   localparam int bit_w = $clog2(pb);

   typedef enum logic [1:0] {scan_load, scan_shift, scan_latch} scan_state_t;

   scan_state_t      phase;
   logic [div_w-1:0] div_cnt;
   logic             tick;         // one half period of ip_clk done
   logic [1:0]       slot;         // slot being shifted
   logic [1:0]       frame_count;  // last slot of this frame
   logic [bit_w-1:0] bit_idx;
   logic             latch_half;   // second half of the latch pulse
   logic [pb-1:0]    shreg;        // current panel word, msb goes out first
   logic [pb-1:0]    frame_words [qsic_pkg::slot_count];  // words frozen at frame start
   logic [pb-1:0]    sel_word [qsic_pkg::slot_count];
   logic [pb-1:0]    monitor_word;
   logic [pb-1:0]    echo_word;

   // read flag, bs7, then the 22 address bits, zero padded at the bottom
   assign monitor_word = {cycle_read, cycle_bs7, cycle_addr,
                          {(pb - qsic_pkg::dal_width - 2){1'b0}}};
   assign echo_word    = {{(pb - qsic_pkg::data_width){1'b0}}, read_data};

   always_comb begin
      for (int i = 0; i < qsic_pkg::slot_count; i++) begin
         case (conf_list[i])
            qsic_pkg::panel_lamptest:    sel_word[i] = '1;
            qsic_pkg::panel_bus_monitor: sel_word[i] = monitor_word;
            qsic_pkg::panel_config_echo: sel_word[i] = echo_word;
            default:                     sel_word[i] = '0;  // dark
         endcase
      end
   end

   assign tick   = (div_cnt == div_w'(ip_div - 1));
   assign ip_out = shreg[pb-1];

   always_ff @(posedge clk20) begin
      if (phase == scan_load) begin
         frame_words <= sel_word;  // whole frame frozen here
      end
   end

   always_ff @(posedge clk20) begin
      if (reset) begin
         phase       <= scan_load;
         div_cnt     <= '0;
         slot        <= '0;
         frame_count <= '0;
         bit_idx     <= '0;
         latch_half  <= 1'b0;
         shreg       <= '0;
         ip_clk      <= 1'b0;
         ip_latch    <= 1'b0;
      end else begin
         div_cnt <= tick ? '0 : div_cnt + 1'b1;
         case (phase)
            scan_load: begin
               div_cnt     <= '0;  // restart so the first half period is full
               frame_count <= conf_count;
               slot        <= '0;
               bit_idx     <= '0;
               shreg       <= sel_word[0];  // first bit set up before the first rise
               phase       <= scan_shift;
            end
            scan_shift: if (tick) begin
               ip_clk <= ~ip_clk;
               if (ip_clk) begin  // falling edge, move to the next bit
                  if (slot == frame_count && bit_idx == bit_w'(pb - 1)) begin
                     ip_latch   <= 1'b1;
                     latch_half <= 1'b0;
                     phase      <= scan_latch;
                  end else if (bit_idx == bit_w'(pb - 1)) begin
                     bit_idx <= '0;
                     slot    <= slot + 2'd1;
                     shreg   <= frame_words[slot + 2'd1];
                  end else begin
                     bit_idx <= bit_idx + 1'b1;
                     shreg   <= {shreg[pb-2:0], 1'b0};
                  end
               end
            end
            scan_latch: if (tick) begin  // ip_clk parked low for the whole pulse
               latch_half <= 1'b1;
               if (latch_half) begin
                  ip_latch <= 1'b0;
                  phase    <= scan_load;
               end
            end
            default: phase <= scan_load;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- design/qsic_slave.sv
// qsic qbus slave top
`timescale 1ns/1ps
`default_nettype none

module qsic_slave #(
   parameter int sync_stages   = 2,
   parameter int settle_cycles = 2,
   parameter int ip_div        = 4
) (
   input  wire logic                           clk20,
   input  wire logic                           reset,
   input  wire logic                           rsync,
   input  wire logic                           rdin,
   input  wire logic                           rdout,
   input  wire logic                           bs7,
   input  wire logic                           wtbt,
   input  wire logic [qsic_pkg::dal_width-1:0] dal_in,
   output logic                                trply,
   output logic                                dal_tx,
   output logic                                dal_st,
   output logic                                dal_be_l,
   output logic [qsic_pkg::dal_width-1:0]      dal_out,
   output logic                                ip_clk,
   output logic                                ip_out,
   output logic                                ip_latch
);

   logic                              s_rsync, s_rdin, rdin_settled, s_rdout, rdout_pulse;
   logic                              cycle_bs7, cycle_read;
   logic [qsic_pkg::dal_width-1:0]    cycle_addr;
   logic                              conf_match;
   logic [qsic_pkg::data_width-1:0]   read_data;
   qsic_pkg::panel_sel_t              conf_list [qsic_pkg::slot_count];
   logic [1:0]                        conf_count;

   qbus_sync #(.sync_stages(sync_stages), .settle_cycles(settle_cycles)) u_sync (
      .clk20, .reset, .rsync, .rdin, .rdout, .bs7, .wtbt, .dal_in,
      .s_rsync, .s_rdin, .rdin_settled, .s_rdout, .rdout_pulse,
      .cycle_bs7, .cycle_read, .cycle_addr
   );

   panel_config u_config (
      .clk20, .reset, .s_rsync, .rdout_pulse, .cycle_bs7, .cycle_addr, .dal_in,
      .conf_match, .read_data, .conf_list, .conf_count
   );

   reply_seq #(.settle_cycles(settle_cycles)) u_reply (
      .clk20, .reset, .conf_match, .s_rdin, .rdin_settled, .s_rdout,
      .trply, .dal_tx, .dal_st, .dal_be_l
   );

   panel_scan #(.ip_div(ip_div)) u_scan (
      .clk20, .reset, .cycle_read, .cycle_bs7, .cycle_addr, .read_data,
      .conf_list, .conf_count, .ip_clk, .ip_out, .ip_latch
   );

   // only the register word goes out, upper address bits stay zero
   assign dal_out = dal_tx ?
      {{(qsic_pkg::dal_width - qsic_pkg::data_width){1'b0}}, read_data} : '0;

endmodule

`default_nettype wire

//--- tb/qsic_slave_sva.sv
// reply sequencer assertions
`timescale 1ns/1ps
`default_nettype none

module qsic_slave_sva (
   input wire logic clk20,
   input wire logic reset,
   input wire logic s_rdin,
   input wire logic rdin_settled,
   input wire logic s_rdout,
   input wire logic trply,
   input wire logic dal_tx,
   input wire logic dal_st,
   input wire logic dal_be_l
);

   // read reply only once the transceivers already faced the bus a clock earlier
   a_read_reply: assert property (@(posedge clk20) disable iff (reset)
      (trply && s_rdin) |-> (dal_tx && $past(dal_tx)))
      else $error("trply high without dal_tx in a read cycle");

   a_latch_drive: assert property (@(posedge clk20) disable iff (reset)
      dal_st |-> (!dal_be_l && $past(rdin_settled)))  // latched data is settled and driven
      else $error("dal_st high before the read strobe settled or with drivers off");

   // every control back at rest the clock after both strobes are low
   a_idle_quiet: assert property (@(posedge clk20) disable iff (reset)
      (!s_rdin && !s_rdout) |=> (!trply && !dal_tx && !dal_st && dal_be_l))
      else $error("control output active with no strobe");

endmodule

bind reply_seq qsic_slave_sva u_reply_sva (
   .clk20, .reset, .s_rdin, .rdin_settled, .s_rdout,
   .trply, .dal_tx, .dal_st, .dal_be_l
);

`default_nettype wire

//--- tb/qsic_slave_tb.sv
// qsic slave testbench
`timescale 1ns/1ps
`default_nettype none

module qsic_slave_tb;

   localparam int n_writes      = 12;
   localparam int n_misses      = 12;
   localparam int bus_cycles    = 2 + 2 * n_writes + n_misses;  // reset read, write+read pairs, misses, last read
   localparam int timeout_limit = bus_cycles * 40 + 4 * 4 * 36 * 8;
   localparam logic [21:0] reg_addr = 22'o17777720;  // config register at the top of the I/O page

   logic        clk20 = 1'b0;
   logic        reset;
   logic        rsync;
   logic        rdin;
   logic        rdout;
   logic        bs7;
   logic        wtbt;
   logic [21:0] dal_in;
   wire logic   trply;
   wire logic   dal_tx;
   wire logic   dal_st;
   wire logic   dal_be_l;
   wire logic   ip_clk;
   wire logic   ip_out;
   wire logic   ip_latch;
   wire logic [21:0] dal_out;

   // reference model of the register and of the last bus cycle
   logic [1:0]  m_list [4];
   logic [1:0]  m_count;
   logic        m_read;
   logic        m_bs7;
   logic [21:0] m_addr;

   integer      seed;
   int          data_errors  = 0;
   int          proto_errors = 0;
   int          frame_errors = 0;
   int          cycle_count  = 0;
   logic        in_read = 1'b0;  // matched DATI in progress
   logic        in_miss = 1'b0;  // cycle that nobody should answer

   qsic_slave u_dut (
      .clk20, .reset, .rsync, .rdin, .rdout, .bs7, .wtbt, .dal_in,
      .trply, .dal_tx, .dal_st, .dal_be_l, .dal_out,
      .ip_clk, .ip_out, .ip_latch
   );

   always #50 clk20 = ~clk20;  // 100 ns period

   // run limit from the bus cycle count and four worst case frames
   always @(posedge clk20) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_limit) begin
         $display("timeout: run did not finish within %0d clock cycles", timeout_limit);
         $display("Done: errors found");
         $finish;
      end
   end

   // control outputs sampled mid cycle, away from the edge that changes them
   always @(negedge clk20) begin
      if (!reset) begin
         if (in_read && trply && !dal_tx) begin
            proto_errors++;
            $display("read cycle: trply is high while dal_tx is still low");
         end
         if (in_read && trply && dal_be_l) begin
            proto_errors++;
            $display("read cycle: trply is high but the bus drivers are off");
         end
         if (in_read && trply && !dal_st) begin
            proto_errors++;
            $display("read cycle: trply is high but dal_st is low");
         end
         if (in_miss && dal_tx) begin
            proto_errors++;
            $display("foreign cycle: dal_tx went high");
         end
         if (dal_st && dal_be_l) begin
            proto_errors++;
            $display("dal_st is high with dal_be_l high");
         end
      end
   end

   // register word by field layout, gap bits zero
   function automatic logic [15:0] conf_word();
      logic [15:0] w;
      w        = '0;
      w[1:0]   = m_list[0];
      w[4:3]   = m_list[1];
      w[7:6]   = m_list[2];
      w[10:9]  = m_list[3];
      w[13:12] = m_count;
      return w;
   endfunction

   function automatic logic [35:0] panel_word(input logic [1:0] sel);
      case (sel)
         2'd0:    return '1;                                 // lamptest
         2'd1:    return {m_read, m_bs7, m_addr, 12'b0};     // bus monitor
         2'd2:    return {20'b0, conf_word()};               // config echo
         default: return '0;                                 // dark
      endcase
   endfunction

   // one QBUS slave cycle: address phase, strobe, wait for reply, release
   task automatic bus_cycle(input string name, input logic is_read, input logic [21:0] addr,
                            input logic sel7, input logic [21:0] wdata, input logic hit,
                            output logic [21:0] rdata);
      logic got;
      int   n;
      got   = 1'b0;
      rdata = '0;
      @(posedge clk20);
      #1;
      in_miss = ~hit;
      in_read = hit & is_read;
      dal_in  = addr;
      bs7     = sel7;
      wtbt    = ~is_read;  // low in the address phase for DATI
      rsync   = 1'b1;
      repeat (5) @(posedge clk20);  // slave latches the address meanwhile
      #1;
      dal_in = is_read ? 22'd0 : wdata;
      if (is_read)
         rdin = 1'b1;
      else
         rdout = 1'b1;
      n = 0;
      while (!got && n < 20) begin
         @(negedge clk20);
         if (trply) begin
            got   = 1'b1;
            rdata = dal_out;  // data on the bus while reply is up
         end
         n++;
      end
      if (hit && !got) begin
         proto_errors++;
         $display("%s: no reply within 20 cycles", name);
      end
      if (!hit && got) begin
         proto_errors++;
         $display("%s: reply to a cycle for another address", name);
      end
      @(posedge clk20);
      #1;
      rdin  = 1'b0;
      rdout = 1'b0;
      n     = 0;
      while (trply && n < 20) begin
         @(negedge clk20);
         n++;
      end
      if (trply || dal_tx || dal_st || !dal_be_l) begin
         proto_errors++;
         $display("%s: controls not back to idle after the strobe dropped", name);
      end
      @(posedge clk20);
      #1;
      rsync   = 1'b0;
      bs7     = 1'b0;
      wtbt    = 1'b0;
      dal_in  = '0;
      in_read = 1'b0;
      in_miss = 1'b0;
      repeat (4) @(posedge clk20);  // rsync low long enough for the next rise
      m_read = is_read;
      m_bs7  = sel7;
      m_addr = addr;
   endtask

   task automatic check_read(input string name);
      logic [21:0] rdata;
      logic [21:0] want;
      want = {6'b0, conf_word()};
      bus_cycle(name, 1'b1, reg_addr, 1'b1, 22'd0, 1'b1, rdata);
      if (rdata !== want) begin
         data_errors++;
         $display("Error %s: expected %h, got %h", name, want, rdata);
      end
   endtask

   task automatic write_conf(input string name, input logic [21:0] addr, input logic [21:0] data);
      logic [21:0] unused;
      bus_cycle(name, 1'b0, addr, 1'b1, data, 1'b1, unused);
      m_list[0] = data[1:0];
      m_list[1] = data[4:3];
      m_list[2] = data[7:6];
      m_list[3] = data[10:9];
      m_count   = data[13:12];
   endtask

   // collect one full frame between two latch pulses
   task automatic check_frame(input string name);
      logic [143:0] want;
      logic [143:0] got;
      logic [35:0]  w;
      logic         last_clk;
      int           want_n;
      int           got_n;
      want   = '0;
      got    = '0;
      got_n  = 0;
      want_n = 36 * (int'(m_count) + 1);
      for (int s = 0; s <= int'(m_count); s++) begin
         w    = panel_word(m_list[s]);
         want = {want[107:0], w};  // slot 0 ends up in front
      end
      @(negedge clk20);
      while (!ip_latch)
         @(negedge clk20);
      while (ip_latch)
         @(negedge clk20);
      last_clk = ip_clk;
      while (!ip_latch) begin
         if (ip_clk && !last_clk) begin  // rising ip_clk seen
            got = {got[142:0], ip_out};
            got_n++;
         end
         last_clk = ip_clk;
         @(negedge clk20);
      end
      if (got_n != want_n) begin
         frame_errors++;
         $display("Error %s: expected %0d bits, got %0d bits", name, want_n, got_n);
      end else if (got != want) begin
         frame_errors++;
         $display("Error %s: expected %h, got %h", name, want, got);
      end
   endtask

   initial begin
      logic [31:0] r;
      logic [21:0] addr;
      logic [21:0] wdata;
      logic [21:0] rdata;
      logic        sel7;
      seed   = 32'h4ab07935;
      reset  = 1'b1;
      rsync  = 1'b0;
      rdin   = 1'b0;
      rdout  = 1'b0;
      bs7    = 1'b0;
      wtbt   = 1'b0;
      dal_in = '0;
      m_list[0] = 2'd2;  // power-up layout echo, monitor, lamptest, monitor
      m_list[1] = 2'd1;
      m_list[2] = 2'd0;
      m_list[3] = 2'd1;
      m_count   = 2'd2;
      m_read    = 1'b0;
      m_bs7     = 1'b0;
      m_addr    = '0;
      repeat (4) @(posedge clk20);
      #1;
      reset = 1'b0;

      check_read("reset_read");
      check_frame("reset_frame");

      for (int i = 0; i < n_writes; i++) begin
         r     = $random(seed);
         addr  = {r[21:13], 13'o17720};  // any upper bits still hit the register
         r     = $random(seed);
         wdata = r[21:0];
         write_conf($sformatf("write_%0d", i), addr, wdata);
         check_read($sformatf("read_%0d", i));
      end

      for (int i = 0; i < n_misses; i++) begin
         r     = $random(seed);
         addr  = r[21:0];
         sel7  = r[31];
         if (sel7 && addr[12:0] == 13'o17720)
            addr[3] = ~addr[3];  // move off the register
         wdata = 22'($random(seed));
         bus_cycle($sformatf("miss_%0d", i), r[30], addr, sel7, wdata, 1'b0, rdata);
      end

      check_read("after_misses");
      check_frame("final_frame");

      $display("errors: %0d data, %0d protocol, %0d frame",
               data_errors, proto_errors, frame_errors);
      if (data_errors + proto_errors + frame_errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

`default_nettype wire

//--- qsic_slave.f
design/qsic_pkg.sv
design/qbus_sync.sv
design/reply_seq.sv
design/panel_config.sv
design/panel_scan.sv
design/qsic_slave.sv
tb/qsic_slave_sva.sv
tb/qsic_slave_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the qsic_slave testbench with Verilator

cd "$(dirname "$0")" || exit 1

build=obj_dir
log=sim.log

verilator --binary --timing --assert --top-module qsic_slave_tb -Mdir "$build" -f qsic_slave.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$build/Vqsic_slave_tb" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Done: no errors$" "$log"; then
   exit 0
fi
echo "simulation reported failure"
exit 1
